// ==== src/mipsPkg.sv ====
package mipsPkg;

    // --------------------------------------------------
    // Widths with a meaning
    // --------------------------------------------------
    typedef logic [31:0] word;      // Data or instruction word
    typedef logic [4:0]  regAddr;   // Register number
    typedef logic [5:0]  opcodeT;   // Primary opcode, bits 31:26
    typedef logic [5:0]  functT;    // R-type funct, bits 5:0
    typedef logic [2:0]  aluCtrl;   // ALU operation
    typedef logic [1:0]  pcSel;     // Next fetch address source
    typedef logic [1:0]  fwdSel;    // Operand bypass source

    // ALU operations
    localparam aluCtrl ALU_ADD = 3'd0;
    localparam aluCtrl ALU_SUB = 3'd1;
    localparam aluCtrl ALU_AND = 3'd2;
    localparam aluCtrl ALU_OR  = 3'd3;
    localparam aluCtrl ALU_SLT = 3'd4;  // Signed compare, 0 or 1

    // Next-PC sources
    localparam pcSel PC_SEQ    = 2'd0;  // PC + 4
    localparam pcSel PC_BRANCH = 2'd1;  // Taken BEQ / BNE
    localparam pcSel PC_JUMP   = 2'd2;  // J and JAL
    localparam pcSel PC_REG    = 2'd3;  // JR target from rs

    // Bypass sources
    localparam fwdSel FWD_REG   = 2'd0; // Register file value
    localparam fwdSel FWD_EXMEM = 2'd1; // ALU result one stage ahead
    localparam fwdSel FWD_MEMWB = 2'd2; // Write-back value

    // --------------------------------------------------
    // Opcodes
    // --------------------------------------------------
    localparam opcodeT OP_RTYPE = 6'h00;
    localparam opcodeT OP_J     = 6'h02;
    localparam opcodeT OP_JAL   = 6'h03;
    localparam opcodeT OP_BEQ   = 6'h04;
    localparam opcodeT OP_BNE   = 6'h05;
    localparam opcodeT OP_ADDI  = 6'h08;
    localparam opcodeT OP_ORI   = 6'h0D;
    localparam opcodeT OP_LW    = 6'h23;
    localparam opcodeT OP_SW    = 6'h2B;

    // R-type functions
    localparam functT FN_JR   = 6'h08;
    localparam functT FN_ADDU = 6'h21;
    localparam functT FN_SUBU = 6'h23;
    localparam functT FN_AND  = 6'h24;
    localparam functT FN_OR   = 6'h25;
    localparam functT FN_SLT  = 6'h2A;

    localparam regAddr RA_REG   = 5'd31;   // JAL link register
    localparam word    RESET_PC = 32'h0;
    localparam word    NOP_WORD = 32'h0;   // sll r0,r0,0 doubles as the bubble

endpackage

// ==== src/alu.sv ====
module alu (
    input  mipsPkg::word    a,
    input  mipsPkg::word    b,
    input  mipsPkg::aluCtrl op,
    output mipsPkg::word    result
);

    always_comb begin
        case (op)
            mipsPkg::ALU_ADD: result = a + b;  // ADDU, ADDI, LW/SW address
            mipsPkg::ALU_SUB: result = a - b;
            mipsPkg::ALU_AND: result = a & b;
            mipsPkg::ALU_OR:  result = a | b;  // OR, ORI
            mipsPkg::ALU_SLT: result = {31'b0, $signed(a) < $signed(b)};
            default:          result = b;      // Pass B through, LUI style
        endcase
    end

endmodule

// ==== src/regFile.sv ====
module regFile (
    input  logic            clock,
    input  logic            reset,
    input  logic            writeEnable,
    input  mipsPkg::regAddr writeAddr,
    input  mipsPkg::regAddr readAddrA,
    input  mipsPkg::regAddr readAddrB,
    input  mipsPkg::word    writeData,
    output mipsPkg::word    readDataA,
    output mipsPkg::word    readDataB
);

    mipsPkg::word regs [32];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (writeAddr != '0)) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Write-before-read so WB and ID can share a cycle
    function automatic mipsPkg::word readPort(input mipsPkg::regAddr addr);
        if (addr == '0) return '0;
        if (writeEnable && (writeAddr == addr)) return writeData;
        return regs[addr];
    endfunction

    always_comb begin
        readDataA = readPort(readAddrA);
        readDataB = readPort(readAddrB);
    end

endmodule

// ==== src/forwardUnit.sv ====
module forwardUnit (
    input  mipsPkg::regAddr idRs,
    input  mipsPkg::regAddr idRt,
    input  mipsPkg::regAddr exRs,
    input  mipsPkg::regAddr exRt,
    input  logic            exMemRegWrite,
    input  mipsPkg::regAddr exMemDest,
    input  logic            memWbRegWrite,
    input  mipsPkg::regAddr memWbDest,
    output mipsPkg::fwdSel  idFwdA,
    output mipsPkg::fwdSel  idFwdB,
    output mipsPkg::fwdSel  exFwdA,
    output mipsPkg::fwdSel  exFwdB
);

    // Nearest producer wins, r0 is never bypassed
    function automatic mipsPkg::fwdSel pickSource(input mipsPkg::regAddr src);
        if ((src != '0) && exMemRegWrite && (exMemDest == src)) begin
            return mipsPkg::FWD_EXMEM;
        end
        if ((src != '0) && memWbRegWrite && (memWbDest == src)) begin
            return mipsPkg::FWD_MEMWB;
        end
        return mipsPkg::FWD_REG;
    endfunction

    // Loads in EX/MEM never reach here unstalled
    always_comb begin
        idFwdA = pickSource(idRs);  // Decode comparator / JR
        idFwdB = pickSource(idRt);
        exFwdA = pickSource(exRs);  // ALU operands
        exFwdB = pickSource(exRt);
    end

endmodule

// ==== src/hazardUnit.sv ====
module hazardUnit (
    input  mipsPkg::word    instr,
    input  logic            branchEqual,
    input  logic            exRegWrite,
    input  logic            exMemRead,
    input  mipsPkg::regAddr exDest,
    input  logic            memRegWrite,
    input  logic            memMemRead,
    input  mipsPkg::regAddr memDest,
    output logic            pcWrite,
    output logic            ifIdWrite,
    output logic            bubble,
    output logic            fetchSquash,
    output mipsPkg::pcSel   pcSource
);

    mipsPkg::opcodeT opcode;
    mipsPkg::functT  funct;
    mipsPkg::regAddr rs;
    mipsPkg::regAddr rt;
    logic isBranch;
    logic isJump;
    logic isJr;
    logic taken;
    logic readsRs;
    logic readsRt;
    logic exDep;
    logic memDep;
    logic stall;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];

    // --------------------------------------------------
    // Decode of the ID instruction
    // --------------------------------------------------
    assign isBranch = (opcode == mipsPkg::OP_BEQ) || (opcode == mipsPkg::OP_BNE);
    assign isJump   = (opcode == mipsPkg::OP_J) || (opcode == mipsPkg::OP_JAL);
    assign isJr     = (opcode == mipsPkg::OP_RTYPE) && (funct == mipsPkg::FN_JR);
    assign taken    = ((opcode == mipsPkg::OP_BEQ) && branchEqual) ||
                      ((opcode == mipsPkg::OP_BNE) && !branchEqual);

    // Source use; r0 never waits
    assign readsRs = !isJump && (rs != '0);
    assign readsRt = ((opcode == mipsPkg::OP_RTYPE) || isBranch ||
                      (opcode == mipsPkg::OP_SW)) && (rt != '0);

    // Producer in EX or MEM writes a source we read
    assign exDep  = exRegWrite &&
                    ((readsRs && (exDest == rs)) || (readsRt && (exDest == rt)));
    assign memDep = memRegWrite &&
                    ((readsRs && (memDest == rs)) || (readsRt && (memDest == rt)));

    // Comparator or JR operand not ready, then plain load-use
    assign stall = ((isBranch || isJr) && (exDep || (memDep && memMemRead))) ||
                   (exMemRead && exDep);

    always_comb begin
        // Pipeline advances by default
        pcWrite     = 1'b1;
        ifIdWrite   = 1'b1;
        bubble      = 1'b0;
        fetchSquash = 1'b0;
        pcSource    = mipsPkg::PC_SEQ;

        if (stall) begin
            pcWrite   = 1'b0;           // Hold fetch address
            ifIdWrite = 1'b0;           // Keep ID instruction
            bubble    = 1'b1;           // Nop into EX
        end else if (taken) begin
            fetchSquash = 1'b1;
            pcSource    = mipsPkg::PC_BRANCH;
        end else if (isJump) begin
            fetchSquash = 1'b1;
            pcSource    = mipsPkg::PC_JUMP;
        end else if (isJr) begin
            fetchSquash = 1'b1;
            pcSource    = mipsPkg::PC_REG;
        end
    end

endmodule

// ==== src/controlDecoder.sv ====
module controlDecoder (
    input  mipsPkg::word    instr,
    output logic            regWrite,
    output logic            memRead,
    output logic            memWrite,
    output logic            aluSrcImm,
    output logic            zeroExtend,
    output logic            link,
    output mipsPkg::aluCtrl aluOp,
    output mipsPkg::regAddr destReg
);

    mipsPkg::opcodeT opcode;
    mipsPkg::functT  funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        // Defaults describe a nop
        regWrite   = 1'b0;
        memRead    = 1'b0;
        memWrite   = 1'b0;
        aluSrcImm  = 1'b0;
        zeroExtend = 1'b0;
        link       = 1'b0;
        aluOp      = mipsPkg::ALU_ADD;
        destReg    = instr[20:16];      // rt for I-type

        case (opcode)
            mipsPkg::OP_RTYPE: begin
                destReg = instr[15:11]; // rd
                case (funct)
                    mipsPkg::FN_ADDU: regWrite = 1'b1;
                    mipsPkg::FN_SUBU: begin
                        regWrite = 1'b1;
                        aluOp    = mipsPkg::ALU_SUB;
                    end
                    mipsPkg::FN_AND: begin
                        regWrite = 1'b1;
                        aluOp    = mipsPkg::ALU_AND;
                    end
                    mipsPkg::FN_OR: begin
                        regWrite = 1'b1;
                        aluOp    = mipsPkg::ALU_OR;
                    end
                    mipsPkg::FN_SLT: begin
                        regWrite = 1'b1;
                        aluOp    = mipsPkg::ALU_SLT;
                    end
                    mipsPkg::FN_JR: regWrite = 1'b0;   // Resolved in decode
                    default:        regWrite = 1'b0;   // Unsupported funct, incl. nop
                endcase
            end
            mipsPkg::OP_ADDI: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
            end
            mipsPkg::OP_ORI: begin
                regWrite   = 1'b1;
                aluSrcImm  = 1'b1;
                zeroExtend = 1'b1;              // Logical immediate
                aluOp      = mipsPkg::ALU_OR;
            end
            mipsPkg::OP_LW: begin
                regWrite  = 1'b1;
                memRead   = 1'b1;
                aluSrcImm = 1'b1;               // Address = rs + offset
            end
            mipsPkg::OP_SW: begin
                memWrite  = 1'b1;
                aluSrcImm = 1'b1;
            end
            mipsPkg::OP_JAL: begin
                regWrite = 1'b1;
                link     = 1'b1;                // PC+4 replaces the ALU result
                destReg  = mipsPkg::RA_REG;
            end
            default: regWrite = 1'b0;           // Branches and J write nothing
        endcase
    end

endmodule

// ==== src/mipsCore.sv ====
module mipsCore (
    input  logic         clock,
    input  logic         reset,
    input  mipsPkg::word instrData,
    input  mipsPkg::word dataReadData,
    output mipsPkg::word instrAddr,
    output mipsPkg::word dataAddr,
    output mipsPkg::word dataWriteData,
    output logic         dataRead,
    output logic         dataWrite
);

    // Fetch and hazard control
    mipsPkg::word  pc;
    mipsPkg::word  pcPlus4;
    mipsPkg::word  nextPc;
    logic          pcWrite;
    logic          ifIdWrite;
    logic          bubble;
    logic          fetchSquash;
    mipsPkg::pcSel pcSource;

    // IF/ID
    mipsPkg::word ifIdInstr;
    mipsPkg::word ifIdPcPlus4;

    // Decode
    mipsPkg::regAddr idRs;
    mipsPkg::regAddr idRt;
    mipsPkg::regAddr idDest;
    logic            idRegWrite;
    logic            idMemRead;
    logic            idMemWrite;
    logic            idAluSrcImm;
    logic            idZeroExtend;
    logic            idLink;
    mipsPkg::aluCtrl idAluOp;
    mipsPkg::word    signImm;
    mipsPkg::word    idImm;
    mipsPkg::word    rfA;
    mipsPkg::word    rfB;
    mipsPkg::word    idOpA;
    mipsPkg::word    idOpB;
    mipsPkg::word    branchTarget;
    mipsPkg::word    jumpTarget;
    logic            branchEqual;
    mipsPkg::fwdSel  idFwdA;
    mipsPkg::fwdSel  idFwdB;
    mipsPkg::fwdSel  exFwdA;
    mipsPkg::fwdSel  exFwdB;

    // ID/EX
    logic            idExRegWrite;
    logic            idExMemRead;
    logic            idExMemWrite;
    logic            idExAluSrcImm;
    logic            idExLink;
    mipsPkg::aluCtrl idExAluOp;
    mipsPkg::regAddr idExRs;
    mipsPkg::regAddr idExRt;
    mipsPkg::regAddr idExDest;
    mipsPkg::word    idExA;
    mipsPkg::word    idExB;
    mipsPkg::word    idExImm;
    mipsPkg::word    idExPcPlus4;

    // Execute, EX/MEM and MEM/WB
    mipsPkg::word    exA;
    mipsPkg::word    exB;
    mipsPkg::word    aluResult;
    mipsPkg::word    exResult;
    logic            exMemRegWrite;
    logic            exMemMemRead;
    logic            exMemMemWrite;
    mipsPkg::regAddr exMemDest;
    mipsPkg::word    exMemResult;
    mipsPkg::word    exMemStoreData;
    mipsPkg::word    memResult;
    logic            memWbRegWrite;
    mipsPkg::regAddr memWbDest;
    mipsPkg::word    memWbData;

    // Shared bypass mux for decode and execute operands
    function automatic mipsPkg::word bypass(input mipsPkg::fwdSel sel,
                                            input mipsPkg::word regVal);
        case (sel)
            mipsPkg::FWD_EXMEM: return exMemResult;
            mipsPkg::FWD_MEMWB: return memWbData;
            default:            return regVal;
        endcase
    endfunction

    // --------------------------------------------------
    // IF
    // --------------------------------------------------
    assign instrAddr = pc;
    assign pcPlus4   = pc + 32'd4;

    always_comb begin
        case (pcSource)
            mipsPkg::PC_BRANCH: nextPc = branchTarget;
            mipsPkg::PC_JUMP:   nextPc = jumpTarget;
            mipsPkg::PC_REG:    nextPc = idOpA;     // JR rs, bypassed
            default:            nextPc = pcPlus4;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= mipsPkg::RESET_PC;
        end else if (pcWrite) begin
            pc <= nextPc;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ifIdInstr <= mipsPkg::NOP_WORD;
        end else if (ifIdWrite) begin
            ifIdInstr <= fetchSquash ? mipsPkg::NOP_WORD : instrData;  // No delay slot
        end
    end

    always_ff @(posedge clock) begin
        if (ifIdWrite) begin
            ifIdPcPlus4 <= pcPlus4;
        end
    end

    // --------------------------------------------------
    // ID, branches and jumps resolve here
    // --------------------------------------------------
    assign idRs         = ifIdInstr[25:21];
    assign idRt         = ifIdInstr[20:16];
    assign signImm      = {{16{ifIdInstr[15]}}, ifIdInstr[15:0]};
    assign idImm        = idZeroExtend ? {16'b0, ifIdInstr[15:0]} : signImm;
    assign branchTarget = ifIdPcPlus4 + {signImm[29:0], 2'b00};
    assign jumpTarget   = {ifIdPcPlus4[31:28], ifIdInstr[25:0], 2'b00};

    always_comb begin
        idOpA = bypass(idFwdA, rfA);
        idOpB = bypass(idFwdB, rfB);
    end

    assign branchEqual = (idOpA == idOpB);

    controlDecoder i_controlDecoder (
        .instr(ifIdInstr),
        .regWrite(idRegWrite),
        .memRead(idMemRead),
        .memWrite(idMemWrite),
        .aluSrcImm(idAluSrcImm),
        .zeroExtend(idZeroExtend),
        .link(idLink),
        .aluOp(idAluOp),
        .destReg(idDest)
    );

    hazardUnit i_hazardUnit (
        .instr(ifIdInstr),
        .branchEqual(branchEqual),
        .exRegWrite(idExRegWrite),
        .exMemRead(idExMemRead),
        .exDest(idExDest),
        .memRegWrite(exMemRegWrite),
        .memMemRead(exMemMemRead),
        .memDest(exMemDest),
        .pcWrite(pcWrite),
        .ifIdWrite(ifIdWrite),
        .bubble(bubble),
        .fetchSquash(fetchSquash),
        .pcSource(pcSource)
    );

    forwardUnit i_forwardUnit (
        .idRs(idRs),
        .idRt(idRt),
        .exRs(idExRs),
        .exRt(idExRt),
        .exMemRegWrite(exMemRegWrite),
        .exMemDest(exMemDest),
        .memWbRegWrite(memWbRegWrite),
        .memWbDest(memWbDest),
        .idFwdA(idFwdA),
        .idFwdB(idFwdB),
        .exFwdA(exFwdA),
        .exFwdB(exFwdB)
    );

    regFile i_regFile (
        .clock(clock),
        .reset(reset),
        .writeEnable(memWbRegWrite),
        .writeAddr(memWbDest),
        .readAddrA(idRs),
        .readAddrB(idRt),
        .writeData(memWbData),
        .readDataA(rfA),
        .readDataB(rfB)
    );

    // ID/EX controls, cleared for a bubble
    always_ff @(posedge clock) begin
        if (reset || bubble) begin
            idExRegWrite  <= 1'b0;
            idExMemRead   <= 1'b0;
            idExMemWrite  <= 1'b0;
            idExAluSrcImm <= 1'b0;
            idExLink      <= 1'b0;
            idExAluOp     <= mipsPkg::ALU_ADD;
            idExRs        <= '0;
            idExRt        <= '0;
            idExDest      <= '0;
        end else begin
            idExRegWrite  <= idRegWrite;
            idExMemRead   <= idMemRead;
            idExMemWrite  <= idMemWrite;
            idExAluSrcImm <= idAluSrcImm;
            idExLink      <= idLink;
            idExAluOp     <= idAluOp;
            idExRs        <= idRs;
            idExRt        <= idRt;
            idExDest      <= idDest;
        end
    end

    always_ff @(posedge clock) begin
        idExA       <= rfA;             // Raw values, EX bypass catches up
        idExB       <= rfB;
        idExImm     <= idImm;
        idExPcPlus4 <= ifIdPcPlus4;     // JAL link value
    end

    // --------------------------------------------------
    // EX
    // --------------------------------------------------
    always_comb begin
        exA = bypass(exFwdA, idExA);
        exB = bypass(exFwdB, idExB);    // Also the SW store data
    end

    alu i_alu (
        .a(exA),
        .b(idExAluSrcImm ? idExImm : exB),
        .op(idExAluOp),
        .result(aluResult)
    );

    assign exResult = idExLink ? idExPcPlus4 : aluResult;

    always_ff @(posedge clock) begin
        if (reset) begin
            exMemRegWrite <= 1'b0;
            exMemMemRead  <= 1'b0;
            exMemMemWrite <= 1'b0;
            exMemDest     <= '0;
        end else begin
            exMemRegWrite <= idExRegWrite;
            exMemMemRead  <= idExMemRead;
            exMemMemWrite <= idExMemWrite;
            exMemDest     <= idExDest;
        end
    end

    always_ff @(posedge clock) begin
        exMemResult    <= exResult;
        exMemStoreData <= exB;
    end

    // --------------------------------------------------
    // MEM and WB
    // --------------------------------------------------
    assign dataAddr      = exMemResult;
    assign dataWriteData = exMemStoreData;
    assign dataRead      = exMemMemRead;
    assign dataWrite     = exMemMemWrite;   // One pulse per SW
    assign memResult     = exMemMemRead ? dataReadData : exMemResult;

    always_ff @(posedge clock) begin
        if (reset) begin
            memWbRegWrite <= 1'b0;
            memWbDest     <= '0;
        end else begin
            memWbRegWrite <= exMemRegWrite;
            memWbDest     <= exMemDest;
        end
    end

    always_ff @(posedge clock) begin
        memWbData <= memResult;
    end

endmodule

// ==== bench/mipsCore_asserts.sv ====
module mipsCoreAsserts (
    input logic clock,
    input logic reset,
    input logic dataRead,
    input logic dataWrite,
    input logic pcWrite,
    input logic ifIdWrite,
    input logic fetchSquash
);

    int failCount = 0;              // Failed assertions so far

    // Memory strobes are exclusive
    strobeExclusive: assert property (@(posedge clock) disable iff (reset)
        !(dataRead && dataWrite))
        else begin
            failCount++;
            $error("dataRead and dataWrite high together");
        end

    // A held PC always holds IF/ID too
    holdTogether: assert property (@(posedge clock) disable iff (reset)
        !pcWrite |-> !ifIdWrite)
        else begin
            failCount++;
            $error("PC held while IF/ID advances");
        end

    // Stall wins over redirect
    squashNeedsAdvance: assert property (@(posedge clock) disable iff (reset)
        fetchSquash |-> pcWrite)
        else begin
            failCount++;
            $error("Fetch squash during a stall");
        end

    // Flushed pipeline issues no store
    noStoreAfterReset: assert property (@(posedge clock)
        reset |=> !dataWrite)
        else begin
            failCount++;
            $error("Store in the cycle after reset");
        end

endmodule

bind mipsCore mipsCoreAsserts i_mipsCoreAsserts (
    .clock(clock),
    .reset(reset),
    .dataRead(dataRead),
    .dataWrite(dataWrite),
    .pcWrite(pcWrite),
    .ifIdWrite(ifIdWrite),
    .fetchSquash(fetchSquash)
);

// ==== bench/mipsCoreTb.sv ====
module mipsCoreTb;

    localparam int MAX_CYCLES = 1000;   // Per wait loop
    localparam logic [31:0] SENTINEL = 32'hFC;

    logic         clock;
    logic         reset;
    mipsPkg::word instrAddr;
    mipsPkg::word instrData;
    mipsPkg::word dataAddr;
    mipsPkg::word dataWriteData;
    mipsPkg::word dataReadData;
    logic         dataRead;
    logic         dataWrite;

    mipsPkg::word imem [256];
    mipsPkg::word dmem [256];
    mipsPkg::word storeAddr [$];    // Observed stores in order
    mipsPkg::word storeData [$];
    mipsPkg::word expAddr [$];      // Expected stores
    mipsPkg::word expData [$];
    logic         sentinelSeen;

    mipsCore i_mipsCore (
        .clock(clock),
        .reset(reset),
        .instrData(instrData),
        .dataReadData(dataReadData),
        .instrAddr(instrAddr),
        .dataAddr(dataAddr),
        .dataWriteData(dataWriteData),
        .dataRead(dataRead),
        .dataWrite(dataWrite)
    );

    always #4 clock = ~clock;       // 8-unit period

    // --------------------------------------------------
    // Memory models with combinational read
    // --------------------------------------------------
    assign instrData    = imem[instrAddr[9:2]];
    assign dataReadData = dataRead ? dmem[dataAddr[9:2]] : 32'hDEAD_BEEF;  // Poison unless read

    always @(posedge clock) begin
        if (dataWrite) begin
            dmem[dataAddr[9:2]] = dataWriteData;
            storeAddr.push_back(dataAddr);
            storeData.push_back(dataWriteData);
            if (dataAddr == SENTINEL) sentinelSeen = 1'b1;
        end
    end

    // Any bound assertion failure ends the run
    always @(i_mipsCore.i_mipsCoreAsserts.failCount) begin
        if (i_mipsCore.i_mipsCoreAsserts.failCount != 0) begin
            $display("A bound assertion on the core failed");
            $display("=== FAIL ===");
            $fatal(1, "Assertion failed");
        end
    end

    // Instruction encoders
    function automatic mipsPkg::word encR(mipsPkg::functT fn, int rs, int rt, int rd);
        return {mipsPkg::OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    function automatic mipsPkg::word encI(mipsPkg::opcodeT op, int rs, int rt,
                                          logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    function automatic mipsPkg::word encJ(mipsPkg::opcodeT op, int index);
        return {op, index[25:0]};
    endfunction

    function automatic mipsPkg::word sext(logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    // --------------------------------------------------
    // Common helpers
    // --------------------------------------------------
    task automatic checkValue(string name, mipsPkg::word expected, mipsPkg::word actual);
        if (expected !== actual) begin
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    task automatic clearMemories();
        for (int i = 0; i < 256; i++) begin
            imem[i] = mipsPkg::NOP_WORD;
            dmem[i] = {16'hD00D, 8'h5A ^ i[7:0], i[7:0]};  // Address-tagged fill
        end
        expAddr.delete();
        expData.delete();
    endtask

    task automatic expectStore(mipsPkg::word addr, mipsPkg::word data);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    task automatic clearStores();
        storeAddr.delete();
        storeData.delete();
        sentinelSeen = 1'b0;
    endtask

    task automatic pulseReset();
        reset = 1'b1;
        repeat (2) @(posedge clock);
        #1 reset = 1'b0;
        clearStores();
    endtask

    task automatic waitSentinel(string name);
        int cycles;
        cycles = 0;
        while (!sentinelSeen) begin
            if (cycles >= MAX_CYCLES) begin
                $display("Timeout: test %s never stored to the sentinel address", name);
                $display("=== FAIL ===");
                $fatal(1, "Hang in %s", name);
            end
            @(posedge clock);
            #1 cycles++;
        end
    endtask

    task automatic compareStores(string name);
        checkValue({name, " store count"}, expAddr.size(), storeAddr.size());
        foreach (expAddr[i]) begin
            checkValue($sformatf("%s store %0d addr", name, i), expAddr[i], storeAddr[i]);
            checkValue($sformatf("%s store %0d data", name, i), expData[i], storeData[i]);
        end
    endtask

    // --------------------------------------------------
    // Programs and tests
    // --------------------------------------------------
    task automatic loadArith(logic [15:0] i1, logic [15:0] i2, logic [15:0] i3);
        mipsPkg::word r1, r2, r3, r4, r5, r6, r7, r8;
        clearMemories();
        imem[0]  = encI(mipsPkg::OP_ADDI, 0, 1, i1);
        imem[1]  = encI(mipsPkg::OP_ADDI, 1, 2, i2);     // EX/MEM bypass
        imem[2]  = encR(mipsPkg::FN_ADDU, 1, 2, 3);      // Both bypass paths
        imem[3]  = encR(mipsPkg::FN_SUBU, 3, 1, 4);
        imem[4]  = encR(mipsPkg::FN_AND, 4, 3, 5);
        imem[5]  = encR(mipsPkg::FN_OR, 5, 2, 6);
        imem[6]  = encR(mipsPkg::FN_SLT, 6, 1, 7);       // Outcome follows the sign of i2
        imem[7]  = encI(mipsPkg::OP_ORI, 7, 8, i3);
        for (int k = 0; k < 6; k++) begin
            imem[8 + k] = encI(mipsPkg::OP_SW, 0, 3 + k, 16'(4 * k));
        end
        imem[14] = encI(mipsPkg::OP_SW, 0, 0, 16'h00FC);
        r1 = sext(i1);
        r2 = r1 + sext(i2);
        r3 = r1 + r2;
        r4 = r3 - r1;
        r5 = r4 & r3;
        r6 = r5 | r2;
        r7 = ($signed(r6) < $signed(r1)) ? 32'd1 : 32'd0;
        r8 = r7 | {16'h0, i3};                           // ORI zero-extends
        expectStore(0, r3);
        expectStore(4, r4);
        expectStore(8, r5);
        expectStore(12, r6);
        expectStore(16, r7);
        expectStore(20, r8);
        expectStore(SENTINEL, 0);
    endtask

    task automatic testArith(logic [15:0] i1, logic [15:0] i2, logic [15:0] i3);
        loadArith(i1, i2, i3);
        pulseReset();
        waitSentinel("arith");
        compareStores("arith");
    endtask

    task automatic testLoadUse();
        logic [15:0] imm;
        mipsPkg::word loaded;
        imm    = 16'($urandom);
        loaded = $urandom;
        clearMemories();
        dmem[16] = loaded;
        dmem[17] = loaded;
        imem[0] = encI(mipsPkg::OP_ADDI, 0, 1, imm);
        imem[1] = encI(mipsPkg::OP_LW, 0, 2, 16'h0040);
        imem[2] = encR(mipsPkg::FN_ADDU, 2, 1, 3);       // Load-use costs one stall
        imem[3] = encI(mipsPkg::OP_SW, 0, 3, 16'h0000);
        imem[4] = encI(mipsPkg::OP_LW, 0, 4, 16'h0044);
        imem[5] = mipsPkg::NOP_WORD;                     // Reference spacing
        imem[6] = encR(mipsPkg::FN_ADDU, 4, 1, 5);
        imem[7] = encI(mipsPkg::OP_SW, 0, 5, 16'h0004);
        imem[8] = encI(mipsPkg::OP_SW, 0, 0, 16'h00FC);
        expectStore(0, loaded + sext(imm));
        expectStore(4, loaded + sext(imm));
        expectStore(SENTINEL, 0);
        pulseReset();
        waitSentinel("loadUse");
        compareStores("loadUse");
    endtask

    task automatic testBranches();
        clearMemories();
        dmem[16] = 32'd7;
        dmem[17] = 32'd5;
        imem[0]  = encI(mipsPkg::OP_ADDI, 0, 1, 16'd5);
        imem[1]  = encI(mipsPkg::OP_ADDI, 0, 2, 16'd5);
        imem[2]  = encI(mipsPkg::OP_BEQ, 1, 2, 16'd2);   // Taken on an ALU source
        imem[3]  = encI(mipsPkg::OP_SW, 0, 1, 16'h0080);
        imem[4]  = encI(mipsPkg::OP_SW, 0, 1, 16'h0084);
        imem[5]  = encI(mipsPkg::OP_LW, 0, 3, 16'h0040);
        imem[6]  = encI(mipsPkg::OP_BNE, 3, 1, 16'd1);   // Taken with the load in EX
        imem[7]  = encI(mipsPkg::OP_SW, 0, 1, 16'h0088);
        imem[8]  = encI(mipsPkg::OP_LW, 0, 4, 16'h0044);
        imem[9]  = encI(mipsPkg::OP_ADDI, 0, 9, 16'd1);
        imem[10] = encI(mipsPkg::OP_BNE, 4, 1, 16'd1);   // Not taken with the load in MEM
        imem[11] = encI(mipsPkg::OP_SW, 0, 9, 16'h008C);
        imem[12] = encI(mipsPkg::OP_ADDI, 1, 5, 16'd3);
        imem[13] = encI(mipsPkg::OP_BEQ, 5, 3, 16'd1);   // 8 vs 7 falls through
        imem[14] = encI(mipsPkg::OP_SW, 0, 5, 16'h0090);
        imem[15] = encR(mipsPkg::FN_SUBU, 5, 9, 6);
        imem[16] = encI(mipsPkg::OP_BEQ, 6, 3, 16'd1);   // 7 vs 7 is taken
        imem[17] = encI(mipsPkg::OP_SW, 0, 6, 16'h0094);
        imem[18] = encI(mipsPkg::OP_SW, 0, 6, 16'h0098);
        imem[19] = encI(mipsPkg::OP_SW, 0, 0, 16'h00FC);
        expectStore(32'h8C, 1);
        expectStore(32'h90, 8);
        expectStore(32'h98, 7);
        expectStore(SENTINEL, 0);
        pulseReset();
        waitSentinel("branches");
        compareStores("branches");
    endtask

    task automatic testJumps();
        clearMemories();
        imem[0]  = encI(mipsPkg::OP_ADDI, 0, 1, 16'h0011);
        imem[1]  = encJ(mipsPkg::OP_JAL, 6);             // Call to 0x18
        imem[2]  = encI(mipsPkg::OP_SW, 0, 31, 16'h00A0); // Return point
        imem[3]  = encJ(mipsPkg::OP_J, 9);
        imem[4]  = encI(mipsPkg::OP_SW, 0, 1, 16'h00A4);
        imem[5]  = encI(mipsPkg::OP_SW, 0, 1, 16'h00A8);
        imem[6]  = encR(mipsPkg::FN_JR, 31, 0, 0);        // Depends on the link
        imem[7]  = encI(mipsPkg::OP_SW, 0, 1, 16'h00AC);
        imem[8]  = encI(mipsPkg::OP_SW, 0, 1, 16'h00B0);
        imem[9]  = encI(mipsPkg::OP_ADDI, 0, 2, 16'd52);
        imem[10] = encR(mipsPkg::FN_ADDU, 2, 0, 3);
        imem[11] = encR(mipsPkg::FN_JR, 3, 0, 0);         // ALU source in EX
        imem[12] = encI(mipsPkg::OP_SW, 0, 1, 16'h00B4);
        imem[13] = encI(mipsPkg::OP_SW, 0, 3, 16'h00B8);
        imem[14] = encI(mipsPkg::OP_SW, 0, 0, 16'h00FC);
        expectStore(32'hA0, 8);                          // JAL at 4 links 8
        expectStore(32'hB8, 52);
        expectStore(SENTINEL, 0);
        pulseReset();
        waitSentinel("jumps");
        compareStores("jumps");
    endtask

    task automatic testMidReset(logic [15:0] i1, logic [15:0] i2, logic [15:0] i3);
        int cycles;
        loadArith(i1, i2, i3);
        pulseReset();
        cycles = 0;
        while (!dataWrite) begin
            if (cycles >= MAX_CYCLES) begin
                $display("Timeout: test midReset saw no store before the reset");
                $display("=== FAIL ===");
                $fatal(1, "Hang in midReset");
            end
            @(posedge clock);
            #1 cycles++;
        end
        reset = 1'b1;                                    // Mid-run
        @(posedge clock);
        #1 checkValue("midReset dataWrite", 0, {31'd0, dataWrite});
        @(posedge clock);
        #1 reset = 1'b0;
        clearStores();
        waitSentinel("midReset");
        compareStores("midReset");
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        logic [15:0] a, b, c;
        clock        = 1'b0;
        reset        = 1'b1;
        sentinelSeen = 1'b0;
        void'($urandom(5063));
        clearMemories();
        a = 16'($urandom);
        b = 16'($urandom);
        c = 16'($urandom);
        repeat (2) @(posedge clock);
        #1;
        testArith(a, b, c);
        testLoadUse();
        testBranches();
        testJumps();
        testMidReset(a, b, c);
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== filelist.f ====
src/mipsPkg.sv
src/alu.sv
src/regFile.sv
src/forwardUnit.sv
src/hazardUnit.sv
src/controlDecoder.sv
src/mipsCore.sv
bench/mipsCore_asserts.sv
bench/mipsCoreTb.sv
